// ==== sim.f ====
+incdir+.
mul_pkg.sv
mul_ifs.sv
mul_operand_prep.sv
booth_pp_gen.sv
wallace_column.sv
mul_compress.sv
mul_result_out.sv
booth_multiplier.sv
tb_clk_gen.sv
booth_multiplier_chk.sv
tb_booth_multiplier.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_booth_multiplier
FILELIST = sim.f
MDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)

run: build
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)

// ==== tb_booth_multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module tb_booth_multiplier;

	localparam int n_dir = 14;
	localparam int n_rows = 40;
	localparam logic [`MUL_XLEN-1:0] ones = '1;
	localparam logic [`MUL_XLEN-1:0] min_v = 64'h8000_0000_0000_0000;
	localparam logic [`MUL_XLEN-1:0] max_v = 64'h7fff_ffff_ffff_ffff;

	typedef struct packed {
		logic mulw;
		logic [1:0] sgn;
		logic [`MUL_XLEN-1:0] a;
		logic [`MUL_XLEN-1:0] b;
		logic [2*`MUL_XLEN-1:0] prod;
	} row_t;

	logic clk;
	logic rst;
	logic mul_valid;
	logic flush;
	logic mulw;
	logic [1:0] mul_signed;
	logic [`MUL_XLEN-1:0] multiplicand;
	logic [`MUL_XLEN-1:0] multiplier;
	logic out_ready;
	logic mul_ready;
	logic out_valid;
	logic [`MUL_XLEN-1:0] result_hi;
	logic [`MUL_XLEN-1:0] result_lo;

	row_t rows [n_rows];
	string names [n_rows];
	int cur_row;
	int exp_q [$];
	int unsigned acc_q [$]; // edge count at which each queued operation was taken
	int unsigned cyc = 0;
	logic check_latency;
	logic random_ready;

	tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

	booth_multiplier i_booth_multiplier (
		.clk(clk), .rst(rst), .mul_valid(mul_valid), .flush(flush), .mulw(mulw),
		.mul_signed(mul_signed), .multiplicand(multiplicand), .multiplier(multiplier),
		.out_ready(out_ready), .mul_ready(mul_ready), .out_valid(out_valid),
		.result_hi(result_hi), .result_lo(result_lo)
	);

	// both operands widened to 128 bits, bit 0 of sgn for the multiplicand
	function automatic logic [2*`MUL_XLEN-1:0] model(input logic word, input logic [1:0] sgn,
			input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
		mul_pkg::operand_u oa;
		mul_pkg::operand_u ob;
		logic [2*`MUL_XLEN-1:0] wa;
		logic [2*`MUL_XLEN-1:0] wb;
		oa.dword = a;
		ob.dword = b;
		if (word) begin
			oa.dword = {{(`MUL_XLEN/2){oa.words.lo_word[`MUL_XLEN/2-1]}}, oa.words.lo_word};
			ob.dword = {{(`MUL_XLEN/2){ob.words.lo_word[`MUL_XLEN/2-1]}}, ob.words.lo_word};
		end
		wa = {{`MUL_XLEN{sgn[0] & oa.dword[`MUL_XLEN-1]}}, oa.dword};
		wb = {{`MUL_XLEN{sgn[1] & ob.dword[`MUL_XLEN-1]}}, ob.dword};
		return wa * wb;
	endfunction

	task automatic set_row(input int i, input string n, input logic w, input logic [1:0] s,
			input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b,
			input logic [`MUL_XLEN-1:0] hi, input logic [`MUL_XLEN-1:0] lo);
		rows[i] = '{mulw: w, sgn: s, a: a, b: b, prod: {hi, lo}};
		names[i] = n;
	endtask

	task automatic fill_table();
		logic w;
		logic [1:0] s;
		logic [`MUL_XLEN-1:0] a;
		logic [`MUL_XLEN-1:0] b;
		logic [2*`MUL_XLEN-1:0] p;
		set_row(0, "ss_small", 1'b0, 2'd3, 64'd3, 64'd5, 64'd0, 64'd15);
		set_row(1, "ss_neg_one", 1'b0, 2'd3, ones, ones, 64'd0, 64'd1);
		set_row(2, "ss_min_min", 1'b0, 2'd3, min_v, min_v, 64'h4000_0000_0000_0000, 64'd0);
		set_row(3, "ss_min_neg_one", 1'b0, 2'd3, min_v, ones, 64'd0, min_v);
		set_row(4, "ss_zero", 1'b0, 2'd3, 64'd0, ones, 64'd0, 64'd0);
		set_row(5, "ss_max_max", 1'b0, 2'd3, max_v, max_v, 64'h3fff_ffff_ffff_ffff, 64'd1);
		set_row(6, "ss_min_max", 1'b0, 2'd3, min_v, max_v, 64'hc000_0000_0000_0000, min_v);
		set_row(7, "uu_ones", 1'b0, 2'd0, ones, ones, 64'hffff_ffff_ffff_fffe, 64'd1);
		set_row(8, "uu_min_two", 1'b0, 2'd0, min_v, 64'd2, 64'd1, 64'd0);
		set_row(9, "su_neg_ones", 1'b0, 2'd1, ones, ones, ones, 64'd1);
		set_row(10, "us_min_neg", 1'b0, 2'd2, min_v, ones, ones, min_v);
		set_row(11, "w_signed", 1'b1, 2'd3, 64'hdead_beef_ffff_fffe, 64'h1234_5678_0000_0003,
			ones, 64'hffff_ffff_ffff_fffa);
		set_row(12, "w_unsigned", 1'b1, 2'd0, 64'hdead_beef_ffff_fffe, 64'h1234_5678_0000_0003,
			64'd2, 64'hffff_ffff_ffff_fffa);
		set_row(13, "w_junk_hi", 1'b1, 2'd3, 64'h0123_4567_8000_0000, 64'hffff_0000_8000_0000,
			64'd0, 64'h4000_0000_0000_0000);
		for (int i = n_dir; i < n_rows; i++) begin
			w = ($urandom_range(3) == 0);
			s = 2'($urandom_range(3));
			a = {$urandom, $urandom};
			b = {$urandom, $urandom};
			p = model(w, s, a, b);
			set_row(i, $sformatf("rand_%0d", i), w, s, a, b, p[2*`MUL_XLEN-1:`MUL_XLEN],
				p[`MUL_XLEN-1:0]);
		end
	endtask

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic present(input int i);
		mul_valid <= 1'b1;
		mulw <= rows[i].mulw;
		mul_signed <= rows[i].sgn;
		multiplicand <= rows[i].a;
		multiplier <= rows[i].b;
		cur_row <= i;
	endtask

	// returns at the edge where the operation is taken
	task automatic issue(input int i);
		present(i);
		do begin
			@(posedge clk);
		end while (!mul_ready);
	endtask

	task automatic drain();
		do begin
			@(negedge clk);
		end while (exp_q.size() != 0);
		@(posedge clk);
	endtask

	task automatic check_result();
		int i;
		int unsigned lat;
		assert (exp_q.size() != 0) else begin
			$display("a result came out with no operation in flight");
			abort_run();
		end
		i = exp_q.pop_front();
		lat = cyc - acc_q.pop_front();
		assert ({result_hi, result_lo} == rows[i].prod) else begin
			$display("CHECK FAILED %s expected %h_%h actual %h_%h", names[i],
				rows[i].prod[2*`MUL_XLEN-1:`MUL_XLEN], rows[i].prod[`MUL_XLEN-1:0],
				result_hi, result_lo);
			abort_run();
		end
		assert (!check_latency || lat == 3) else begin
			$display("CHECK FAILED %s latency expected 3 actual %0d", names[i], lat);
			abort_run();
		end
	endtask

	// scoreboard, sees the values that stood before each edge
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!rst) begin
			if (out_valid && out_ready && !flush)
				check_result();
			if (flush) begin
				exp_q.delete();
				acc_q.delete();
			end else if (mul_valid && mul_ready) begin
				exp_q.push_back(cur_row);
				acc_q.push_back(cyc);
			end
		end
	end

	always @(posedge clk)
		if (random_ready)
			out_ready <= ($urandom_range(1) != 0);

	initial begin
		repeat (n_rows * 20 + 200) @(posedge clk);
		$display("timeout, the pipeline stopped returning results");
		abort_run();
	end

	initial begin
		void'($urandom(32'h4c2c_2126));
		mul_valid <= 1'b0;
		flush <= 1'b0;
		mulw <= 1'b0;
		mul_signed <= 2'd0;
		multiplicand <= '0;
		multiplier <= '0;
		out_ready <= 1'b0;
		cur_row <= 0;
		check_latency <= 1'b0;
		random_ready <= 1'b0;
		fill_table();
		wait (!rst);
		@(posedge clk);
		assert (!out_valid && mul_ready) else begin
			$display("CHECK FAILED reset expected out_valid 0 mul_ready 1 actual %0b %0b",
				out_valid, mul_ready);
			abort_run();
		end

		// one operation at a time on an empty pipeline
		out_ready <= 1'b1;
		check_latency <= 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			issue(i);
			mul_valid <= 1'b0;
			drain();
		end

		// back to back with a stalling consumer
		check_latency <= 1'b0;
		random_ready <= 1'b1;
		for (int i = 0; i < n_rows; i++)
			issue(i);
		mul_valid <= 1'b0;
		drain();
		random_ready <= 1'b0;
		@(posedge clk);

		// fill all three stages, then flush with a new offer on the same edge
		out_ready <= 1'b0;
		for (int i = 0; i < 3; i++)
			issue(i);
		mul_valid <= 1'b0;
		repeat (2) @(posedge clk);
		present(3);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		mul_valid <= 1'b0;
		out_ready <= 1'b1;
		for (int i = 4; i < 7; i++)
			issue(i);
		mul_valid <= 1'b0;
		drain();
		repeat (5) @(posedge clk); // any late or duplicate result trips the scoreboard
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== booth_multiplier_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module booth_multiplier_chk (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic mul_valid,
	input wire logic mul_ready,
	input wire logic mulw,
	input wire logic [1:0] mul_signed,
	input wire logic [`MUL_XLEN-1:0] multiplicand,
	input wire logic [`MUL_XLEN-1:0] multiplier,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire logic [`MUL_XLEN-1:0] result_hi,
	input wire logic [`MUL_XLEN-1:0] result_lo
);

	// an offer that is not taken stays on the bus unchanged
	in_hold: assert property (@(posedge clk) disable iff (rst)
		mul_valid && !mul_ready && !flush |=> mul_valid
			&& $stable({mulw, mul_signed, multiplicand, multiplier}))
		else $error("operands changed while mul_ready was low");

	out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready && !flush |=> out_valid && $stable({result_hi, result_lo}))
		else $error("result changed while out_ready was low");

	reset_state: assert property (@(posedge clk) rst |=> !out_valid && mul_ready)
		else $error("handshake outputs wrong after reset");

	flush_drop: assert property (@(posedge clk) flush |=> !out_valid)
		else $error("out_valid seen in the cycle after a flush");

endmodule

bind booth_multiplier booth_multiplier_chk i_chk (
	.clk(clk), .rst(rst), .flush(flush),
	.mul_valid(mul_valid), .mul_ready(mul_ready), .mulw(mulw), .mul_signed(mul_signed),
	.multiplicand(multiplicand), .multiplier(multiplier),
	.out_valid(out_valid), .out_ready(out_ready),
	.result_hi(result_hi), .result_lo(result_lo)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// reset held over the first eight rising edges
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== booth_multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module booth_multiplier (
	input wire logic clk,
	input wire logic rst,
	input wire logic mul_valid,
	input wire logic flush,
	input wire logic mulw,
	input wire logic [1:0] mul_signed,
	input wire logic [`MUL_XLEN-1:0] multiplicand,
	input wire logic [`MUL_XLEN-1:0] multiplier,
	input wire logic out_ready,
	output logic mul_ready,
	output logic out_valid,
	output logic [`MUL_XLEN-1:0] result_hi,
	output logic [`MUL_XLEN-1:0] result_lo
);

	mul_opnd_if i_opnd_if ();
	mul_sum_if i_sum_if ();

	mul_operand_prep i_operand_prep (
		.clk(clk), .rst(rst), .flush(flush),
		.mul_valid(mul_valid), .mulw(mulw), .mul_signed(mul_signed),
		.multiplicand(multiplicand), .multiplier(multiplier),
		.mul_ready(mul_ready),
		.opnd(i_opnd_if.src)
	);

	mul_compress i_compress (
		.clk(clk), .rst(rst), .flush(flush),
		.opnd(i_opnd_if.dst),
		.sums(i_sum_if.src)
	);

	mul_result_out i_result_out (
		.clk(clk), .rst(rst), .flush(flush), .out_ready(out_ready),
		.sums(i_sum_if.dst),
		.out_valid(out_valid), .result_hi(result_hi), .result_lo(result_lo)
	);

endmodule

`default_nettype wire

// ==== mul_result_out.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_result_out (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic out_ready,
	mul_sum_if.dst sums,
	output logic out_valid,
	output logic [`MUL_XLEN-1:0] result_hi,
	output logic [`MUL_XLEN-1:0] result_lo
);

	mul_pkg::product_u prod;
	logic valid_q;
	logic [`MUL_XLEN-1:0] hi_q;
	logic [`MUL_XLEN-1:0] lo_q;

	// carry propagate add, the last negate bit rides in as the carry into bit 0
	assign prod.raw = sums.sum.raw + sums.carry.raw
		+ {{(`MUL_PROD_W-1){1'b0}}, sums.neg_lsb};

	assign sums.ready = ~valid_q | out_ready;
	assign out_valid = valid_q;
	assign result_hi = hi_q;
	assign result_lo = lo_q;

	always_ff @(posedge clk) begin
		if (rst || flush)
			valid_q <= 1'b0;
		else if (sums.ready)
			valid_q <= sums.valid;
	end

	// holds while the execute stage is not taking the result
	always_ff @(posedge clk) begin
		if (sums.valid && sums.ready) begin
			hi_q <= prod.f.hi;
			lo_q <= prod.f.lo;
		end
	end

endmodule

`default_nettype wire

// ==== mul_compress.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_compress (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	mul_opnd_if.dst opnd,
	mul_sum_if.src sums
);

	logic [`MUL_EXT_W:0] a_pad;
	logic [`MUL_PROD_W-1:0] mcand_ext;
	logic [`MUL_PROD_W-1:0] pp [`MUL_PP_N];
	logic [`MUL_PP_N-1:0] neg;
	logic [`MUL_PP_N-1:0] col_din [`MUL_PROD_W];
	logic [`MUL_PP_N-3:0] col_cin [`MUL_PROD_W];
	logic [`MUL_PROD_W-1:0] col_sum;
	logic [`MUL_PROD_W-2:0] col_carry;
	logic valid_q;
	mul_pkg::product_u sum_q;
	mul_pkg::product_u carry_q;
	logic neg_lsb_q;

	assign a_pad = {opnd.mul_a, 1'b0}; // implicit zero below bit 0 for the first group
	// the multiplicand must be sign extended over the whole product or signed results go wrong
	assign mcand_ext = {{(`MUL_PROD_W-`MUL_EXT_W){opnd.mul_b[`MUL_EXT_W-1]}}, opnd.mul_b};

	for (genvar g = 0; g < `MUL_PP_N; g++) begin : g_pp
		booth_pp_gen i_pp (
			.group(a_pad[2*g+2:2*g]),
			.mcand(mcand_ext << (2*g)),
			.pp(pp[g]),
			.neg(neg[g])
		);
		for (genvar c = 0; c < `MUL_PROD_W; c++) begin : g_tr
			assign col_din[c][g] = pp[g][c];
		end
	end

	assign col_cin[0] = neg[`MUL_PP_N-3:0];

	for (genvar c = 0; c < `MUL_PROD_W; c++) begin : g_col
		if (c < `MUL_PROD_W-1) begin : g_mid
			wallace_column i_col (.din(col_din[c]), .cin(col_cin[c]), .cout(col_cin[c+1]),
				.carry(col_carry[c]), .sum(col_sum[c]));
		end else begin : g_top
			// carries out of the top column weigh 2**132 and wrap away
			wallace_column i_col (.din(col_din[c]), .cin(col_cin[c]), .cout(),
				.carry(), .sum(col_sum[c]));
		end
	end

	assign opnd.ready = ~valid_q | sums.ready;
	assign sums.valid = valid_q;
	assign sums.sum = sum_q;
	assign sums.carry = carry_q;
	assign sums.neg_lsb = neg_lsb_q;

	always_ff @(posedge clk) begin
		if (rst || flush)
			valid_q <= 1'b0;
		else if (opnd.ready)
			valid_q <= opnd.valid;
	end

	always_ff @(posedge clk) begin
		if (opnd.valid && opnd.ready) begin
			sum_q.raw <= col_sum;
			carry_q.raw <= {col_carry, neg[`MUL_PP_N-2]};
			neg_lsb_q <= neg[`MUL_PP_N-1];
		end
	end

endmodule

`default_nettype wire

// ==== wallace_column.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module wallace_column (
	input wire logic [`MUL_PP_N-1:0] din,
	input wire logic [`MUL_PP_N-3:0] cin,
	output logic [`MUL_PP_N-3:0] cout,
	output logic carry,
	output logic sum
);

	logic [10:0] s1;
	logic [21:0] l2;
	logic [7:0] s2;
	logic [14:0] l3;
	logic [4:0] s3;
	logic [9:0] l4;
	logic [3:0] s4;
	logic [6:0] l5;
	logic [2:0] s5;
	logic [4:0] l6;
	logic [2:0] s6;
	logic [3:0] l7;
	logic [1:0] s7;
	logic [2:0] l8;
	logic s8;

	function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
		return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
	endfunction

	// each level mixes in the carries that the previous column made one level earlier
	always_comb begin
		for (int k = 0; k < 11; k++)
			{cout[k], s1[k]} = fa(din[3*k], din[3*k+1], din[3*k+2]);
		l2 = {cin[10:0], s1};
		for (int k = 0; k < 7; k++)
			{cout[11+k], s2[k]} = fa(l2[3*k], l2[3*k+1], l2[3*k+2]);
		s2[7] = l2[21];
		l3 = {cin[17:11], s2};
		for (int k = 0; k < 5; k++)
			{cout[18+k], s3[k]} = fa(l3[3*k], l3[3*k+1], l3[3*k+2]);
		l4 = {cin[22:18], s3};
		for (int k = 0; k < 3; k++)
			{cout[23+k], s4[k]} = fa(l4[3*k], l4[3*k+1], l4[3*k+2]);
		s4[3] = l4[9];
		l5 = {cin[25:23], s4};
		for (int k = 0; k < 2; k++)
			{cout[26+k], s5[k]} = fa(l5[3*k], l5[3*k+1], l5[3*k+2]);
		s5[2] = l5[6];
		l6 = {cin[27:26], s5};
		{cout[28], s6[0]} = fa(l6[0], l6[1], l6[2]);
		s6[2:1] = l6[4:3];
		l7 = {cin[28], s6};
		{cout[29], s7[0]} = fa(l7[0], l7[1], l7[2]);
		s7[1] = l7[3];
		l8 = {cin[29], s7};
		{cout[30], s8} = fa(l8[0], l8[1], l8[2]);
		{carry, sum} = fa(s8, cin[30], 1'b0); // last level is a half adder
	end

endmodule

`default_nettype wire

// ==== booth_pp_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module booth_pp_gen (
	input wire logic [2:0] group,
	input wire logic [`MUL_PROD_W-1:0] mcand,
	output logic [`MUL_PROD_W-1:0] pp,
	output logic neg
);

	logic [`MUL_PROD_W-1:0] mag;

	always_comb begin
		case (group)
			3'b001, 3'b010, 3'b101, 3'b110:
				mag = mcand;
			3'b011, 3'b100:
				mag = {mcand[`MUL_PROD_W-2:0], 1'b0};
			default:
				mag = '0; // 000 and 111 select zero
		endcase
	end

	// 111 is minus zero, treated as plus zero so no stray +1 goes into the tree
	assign neg = group[2] & ~(group[1] & group[0]);

	// the +1 of the two's complement lands at bit 0 since the low zeros are inverted too
	assign pp = neg ? ~mag : mag;

endmodule

`default_nettype wire

// ==== mul_operand_prep.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_operand_prep (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic mul_valid,
	input wire logic mulw,
	input wire logic [1:0] mul_signed,
	input wire logic [`MUL_XLEN-1:0] multiplicand,
	input wire logic [`MUL_XLEN-1:0] multiplier,
	output logic mul_ready,
	mul_opnd_if.src opnd
);

	mul_pkg::operand_u a_in;
	mul_pkg::operand_u b_in;
	logic valid_q;
	logic [`MUL_EXT_W-1:0] a_q;
	logic [`MUL_EXT_W-1:0] b_q;

	// word mode takes the low word sign extended, then two more copies of the sign on top
	function automatic logic [`MUL_EXT_W-1:0] extend(input mul_pkg::operand_u op,
			input logic word, input logic sgn);
		logic [`MUL_XLEN-1:0] v;
		v = word ? {{(`MUL_XLEN/2){op.words.lo_word[`MUL_XLEN/2-1]}}, op.words.lo_word}
			: op.dword;
		return {{(`MUL_EXT_W-`MUL_XLEN){sgn & v[`MUL_XLEN-1]}}, v};
	endfunction

	assign a_in.dword = multiplicand;
	assign b_in.dword = multiplier;

	assign mul_ready = ~valid_q | opnd.ready;
	assign opnd.valid = valid_q;
	assign opnd.mul_a = a_q;
	assign opnd.mul_b = b_q;

	always_ff @(posedge clk) begin
		if (rst || flush)
			valid_q <= 1'b0; // an operand offered with flush is dropped
		else if (mul_ready)
			valid_q <= mul_valid;
	end

	always_ff @(posedge clk) begin
		if (mul_valid && mul_ready) begin
			a_q <= extend(a_in, mulw, mul_signed[0]);
			b_q <= extend(b_in, mulw, mul_signed[1]);
		end
	end

endmodule

`default_nettype wire

// ==== mul_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

// extended operands from the input side to the Booth array
interface mul_opnd_if;
	logic valid;
	logic ready;
	logic [`MUL_EXT_W-1:0] mul_a;
	logic [`MUL_EXT_W-1:0] mul_b;

	modport src (output valid, output mul_a, output mul_b, input ready);
	modport dst (input valid, input mul_a, input mul_b, output ready);
endinterface

// redundant sum/carry form of the product, resolved by the final adder
interface mul_sum_if;
	logic valid;
	logic ready;
	mul_pkg::product_u sum;
	mul_pkg::product_u carry; // column carries one place up, bit 0 is a negate bit
	logic neg_lsb;

	modport src (
		output valid, output sum, output carry, output neg_lsb,
		input ready
	);
	modport dst (
		input valid, input sum, input carry, input neg_lsb,
		output ready
	);
endinterface

`default_nettype wire

// ==== mul_pkg.sv ====
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

	typedef struct packed {
		logic [`MUL_XLEN/2-1:0] hi_word;
		logic [`MUL_XLEN/2-1:0] lo_word;
	} dword_t;

	// a doubleword operand, or two words when mulw only looks at the low one
	typedef union packed {
		logic [`MUL_XLEN-1:0] dword;
		dword_t words;
	} operand_u;

	typedef struct packed {
		logic [`MUL_PROD_W-`MUL_XLEN*2-1:0] ext; // wraps away, only kept for the width
		logic [`MUL_XLEN-1:0] hi;
		logic [`MUL_XLEN-1:0] lo;
	} prod_fields_t;

	typedef union packed {
		logic [`MUL_PROD_W-1:0] raw;
		prod_fields_t f;
	} product_u;

endpackage

`default_nettype wire

// ==== mul_consts.svh ====
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand width of the integer datapath
`define MUL_XLEN 64

// operand plus two sign bits, so signed and unsigned share one Booth array
`define MUL_EXT_W 66

`define MUL_PP_N 33

`define MUL_PROD_W 132

`endif
